// ==== design/rvvi_consts.svh ====
//////////////////////////////
// Constants of the retirement tracer
// Widths, kept CSR addresses, fault causes
// Observed interrupt lines, halt hold, event credits
//////////////////////////////

`ifndef RVVI_CONSTS_SVH
`define RVVI_CONSTS_SVH

// Widths
`define RVVI_XLEN          32
`define RVVI_ORDER_W       64
`define RVVI_NUM_GPR       32
`define RVVI_GPR_AW        5
`define RVVI_NUM_CSR       4
`define RVVI_CSR_AW        12
`define RVVI_TRAP_CAUSE_W  6
`define RVVI_INTR_CAUSE_W  11

// Kept machine CSRs
`define RVVI_CSR_MSTATUS   12'h300
`define RVVI_CSR_MSCRATCH  12'h340
`define RVVI_CSR_MEPC      12'h341
`define RVVI_CSR_MCAUSE    12'h342

// NMI and fetch fault causes
`define RVVI_NMI_LOAD_CAUSE   11'd1024
`define RVVI_NMI_STORE_CAUSE  11'd1025
`define RVVI_IBUS_FAULT_CAUSE 6'd48

// msip, mtip, meip and the 16 local lines
`define RVVI_IRQ_MASK      32'hFFFF_0888

// Halt request hold after the pin drops
`define RVVI_HALT_HOLD     5

// Event channel
`define RVVI_EVT_CREDITS   2
`define RVVI_NUM_NET       5
`define RVVI_REQ_PER_SRC   2

`endif

// ==== design/rvvi_pkg.sv ====
//////////////////////////////
// Types of the retirement tracer
// Retirement, CSR port and trace records
// Net identifiers and net events
//////////////////////////////

`include "rvvi_consts.svh"

package rvvi_pkg;

   typedef logic [`RVVI_XLEN-1:0] xlen_t;

   typedef struct packed {
      logic                          trap;
      logic                          exception;
      logic [`RVVI_TRAP_CAUSE_W-1:0] cause;
   } trap_t;

   typedef struct packed {
      logic                          intr;
      logic                          interrupt;
      logic [`RVVI_INTR_CAUSE_W-1:0] cause;
   } intr_t;

   // One retired instruction as seen from the core
   typedef struct packed {
      logic                     valid;
      logic [`RVVI_ORDER_W-1:0] order;
      xlen_t                    insn;
      trap_t                    trap;
      intr_t                    intr;
      xlen_t                    pc_rdata;
      xlen_t                    pc_wdata;
      logic [`RVVI_GPR_AW-1:0]  rd_addr;
      xlen_t                    rd_wdata;
   } retire_rec_t;

   typedef struct packed {
      xlen_t wdata;
      xlen_t wmask;
      xlen_t rdata;
      xlen_t rmask;
   } csr_port_t;

   // CSR slots in order mstatus, mepc, mcause, mscratch
   typedef struct packed {
      logic                                           valid;
      logic [`RVVI_ORDER_W-1:0]                       order;
      xlen_t                                          insn;
      xlen_t                                          pc_rdata;
      xlen_t                                          pc_wdata;
      logic [`RVVI_NUM_GPR-1:0]                       x_wb;
      xlen_t                                          x_wdata;
      logic [`RVVI_NUM_CSR-1:0][`RVVI_CSR_AW-1:0]     csr_addr;
      xlen_t [`RVVI_NUM_CSR-1:0]                      csr_val;
      logic [`RVVI_NUM_CSR-1:0]                       csr_wb;
   } trace_rec_t;

   typedef enum logic [2:0] {
      NET_HALTREQ,
      NET_NMI,
      NET_NMI_CAUSE,
      NET_IBUS_FAULT,
      NET_IRQ
   } net_id_e;

   typedef struct packed {
      net_id_e id;
      xlen_t   value;
   } net_event_t;

endpackage

// ==== design/rvvi_csr_merge.sv ====
//////////////////////////////
// CSR value merge
// Write/read mask combining per kept CSR
// Written-since-retirement flags
//////////////////////////////

`timescale 1ns/10ps
`include "rvvi_consts.svh"

module rvvi_csr_merge
   import rvvi_pkg::*;
(
   input  logic                               rvvi,
   input  logic                               arst_n_i,
   input  csr_port_t [`RVVI_NUM_CSR-1:0]      csr_i,
   input  logic                               retire_valid_i,
   output xlen_t [`RVVI_NUM_CSR-1:0]          csr_val_o,
   output logic [`RVVI_NUM_CSR-1:0]           csr_wb_o
);

   xlen_t [`RVVI_NUM_CSR-1:0] merged;
   xlen_t [`RVVI_NUM_CSR-1:0] prev_q;
   logic [`RVVI_NUM_CSR-1:0]  changed;
   logic [`RVVI_NUM_CSR-1:0]  wb_q;

   // Written bits win, read bits only where readable and not written
   always_comb begin
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         merged[i]  = (csr_i[i].wdata & csr_i[i].wmask) |
                      (csr_i[i].rdata & ~csr_i[i].wmask & csr_i[i].rmask);
         changed[i] = merged[i] != prev_q[i];
      end
   end

   assign csr_val_o = merged;
   // Include a change seen in the retiring cycle itself
   assign csr_wb_o  = wb_q | changed;

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         prev_q <= '0;
         wb_q   <= '0;
      end else begin
         prev_q <= merged;
         if (retire_valid_i) begin
            wb_q <= '0;
         end else begin
            wb_q <= wb_q | changed;
         end
      end
   end

endmodule

// ==== design/rvvi_retire_fmt.sv ====
//////////////////////////////
// Retirement formatter
// Trace record register, GPR one-hot writeback
//////////////////////////////

`timescale 1ns/10ps
`include "rvvi_consts.svh"

module rvvi_retire_fmt
   import rvvi_pkg::*;
(
   input  logic                          rvvi,
   input  logic                          arst_n_i,
   input  retire_rec_t                   retire_i,
   input  csr_port_t [`RVVI_NUM_CSR-1:0] csr_i,
   output trace_rec_t                    trace_o
);

   xlen_t [`RVVI_NUM_CSR-1:0] csr_val;
   logic [`RVVI_NUM_CSR-1:0]  csr_wb;
   trace_rec_t                rec_d;
   trace_rec_t                rec_q;

   rvvi_csr_merge u_csr_merge (
      .rvvi           (rvvi),
      .arst_n_i       (arst_n_i),
      .csr_i          (csr_i),
      .retire_valid_i (retire_i.valid),
      .csr_val_o      (csr_val),
      .csr_wb_o       (csr_wb)
   );

   always_comb begin
      rec_d          = '0;
      rec_d.valid    = retire_i.valid;
      rec_d.order    = retire_i.order;
      rec_d.insn     = retire_i.insn;
      rec_d.pc_rdata = retire_i.pc_rdata;
      rec_d.pc_wdata = retire_i.pc_wdata;
      // x0 is never reported as written
      if (retire_i.rd_addr != '0) begin
         rec_d.x_wb[retire_i.rd_addr] = 1'b1;
      end
      rec_d.x_wdata     = retire_i.rd_wdata;
      rec_d.csr_addr[0] = `RVVI_CSR_MSTATUS;
      rec_d.csr_addr[1] = `RVVI_CSR_MEPC;
      rec_d.csr_addr[2] = `RVVI_CSR_MCAUSE;
      rec_d.csr_addr[3] = `RVVI_CSR_MSCRATCH;
      rec_d.csr_val     = csr_val;
      rec_d.csr_wb      = csr_wb;
   end

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rec_q <= '0;
      end else if (retire_i.valid) begin
         rec_q <= rec_d;
      end else begin
         rec_q.valid <= 1'b0;
      end
   end

   assign trace_o = rec_q;

endmodule

// ==== design/rvvi_fault_tracker.sv ====
//////////////////////////////
// NMI and fetch fault tracker
// Data and instruction bus fault state
// Edge events toward the arbiter
//////////////////////////////

`timescale 1ns/10ps
`include "rvvi_consts.svh"

module rvvi_fault_tracker
   import rvvi_pkg::*;
(
   input  logic                                   rvvi,
   input  logic                                   arst_n_i,
   input  retire_rec_t                            retire_i,
   output logic [`RVVI_REQ_PER_SRC-1:0]           req_valid_o,
   output net_event_t [`RVVI_REQ_PER_SRC-1:0]     req_o
);

   logic dbus_q, ibus_q, ibus_pend_q;
   logic nmi_hit, ibus_hit, nmi_req, ibus_req, ibus_any, ibus_val;
   logic [`RVVI_REQ_PER_SRC-1:0]       valid_d;
   net_event_t [`RVVI_REQ_PER_SRC-1:0] req_d;

   always_comb begin
      nmi_hit  = retire_i.valid && retire_i.intr.intr && retire_i.intr.interrupt &&
                 (retire_i.intr.cause == `RVVI_NMI_LOAD_CAUSE ||
                  retire_i.intr.cause == `RVVI_NMI_STORE_CAUSE);
      ibus_hit = retire_i.valid && retire_i.trap.trap && retire_i.trap.exception &&
                 retire_i.trap.cause == `RVVI_IBUS_FAULT_CAUSE;
      // A request whenever a retirement flips the fault state
      nmi_req  = retire_i.valid && (nmi_hit != dbus_q);
      ibus_req = retire_i.valid && (ibus_hit != ibus_q);
      // Deferred fetch event carries the state it left behind
      ibus_any = ibus_req || ibus_pend_q;
      ibus_val = ibus_req ? ibus_hit : ibus_q;

      valid_d = '0;
      req_d   = '0;
      if (nmi_hit) begin
         valid_d[0]     = 1'b1;
         req_d[0].id    = NET_NMI_CAUSE;
         req_d[0].value = xlen_t'(retire_i.intr.cause);
      end else if (ibus_any) begin
         valid_d[0]     = 1'b1;
         req_d[0].id    = NET_IBUS_FAULT;
         req_d[0].value = xlen_t'(ibus_val);
      end
      if (nmi_req) begin
         valid_d[1]     = 1'b1;
         req_d[1].id    = NET_NMI;
         req_d[1].value = xlen_t'(nmi_hit);
      end else if (ibus_any && nmi_hit) begin
         valid_d[1]     = 1'b1;
         req_d[1].id    = NET_IBUS_FAULT;
         req_d[1].value = xlen_t'(ibus_val);
      end
   end

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dbus_q      <= 1'b0;
         ibus_q      <= 1'b0;
         ibus_pend_q <= 1'b0;
         req_valid_o <= '0;
         req_o       <= '0;
      end else begin
         if (retire_i.valid) begin
            dbus_q <= nmi_hit;
            ibus_q <= ibus_hit;
         end
         // Both slots taken by the NMI pair
         ibus_pend_q <= ibus_any && nmi_hit && nmi_req;
         req_valid_o <= valid_d;
         req_o       <= req_d;
      end
   end

endmodule

// ==== design/rvvi_pin_watch.sv ====
//////////////////////////////
// Pin watcher
// Masked interrupt line change detect
// Debug halt request stretch
//////////////////////////////

`timescale 1ns/10ps
`include "rvvi_consts.svh"

module rvvi_pin_watch
   import rvvi_pkg::*;
(
   input  logic                                   rvvi,
   input  logic                                   arst_n_i,
   input  xlen_t                                  irq_i,
   input  logic                                   debug_req_i,
   output logic [`RVVI_REQ_PER_SRC-1:0]           req_valid_o,
   output net_event_t [`RVVI_REQ_PER_SRC-1:0]     req_o
);

   localparam int HOLD_W = $clog2(`RVVI_HALT_HOLD + 1);

   xlen_t                              irq_masked;
   xlen_t                              irq_q;
   logic                               dbg_q;
   logic [HOLD_W-1:0]                  hold_q, hold_d;
   logic [`RVVI_REQ_PER_SRC-1:0]       valid_d;
   net_event_t [`RVVI_REQ_PER_SRC-1:0] req_d;

   assign irq_masked = irq_i & `RVVI_IRQ_MASK;

   always_comb begin
      valid_d = '0;
      req_d   = '0;
      hold_d  = hold_q;

      // Slot 1 reports the whole masked vector
      req_d[1].id    = NET_IRQ;
      req_d[1].value = irq_masked;
      valid_d[1]     = irq_masked != irq_q;

      ///////////////////////////////
      // Halt request
      req_d[0].id = NET_HALTREQ;
      if (debug_req_i) begin
         hold_d = HOLD_W'(`RVVI_HALT_HOLD);
         if (!dbg_q) begin
            valid_d[0]     = 1'b1;
            req_d[0].value = xlen_t'(1'b1);
         end
      end else if (hold_q != '0) begin
         hold_d = hold_q - HOLD_W'(1);
         // Release once the hold runs out
         valid_d[0] = hold_q == HOLD_W'(1);
      end
   end

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         irq_q       <= '0;
         dbg_q       <= 1'b0;
         hold_q      <= '0;
         req_valid_o <= '0;
         req_o       <= '0;
      end else begin
         irq_q       <= irq_masked;
         dbg_q       <= debug_req_i;
         hold_q      <= hold_d;
         req_valid_o <= valid_d;
         req_o       <= req_d;
      end
   end

endmodule

// ==== design/rvvi_event_arbiter.sv ====
//////////////////////////////
// Net event arbiter
// One pending slot per net id, last value wins
// Fixed priority pick under credit flow
//////////////////////////////

`timescale 1ns/10ps
`include "rvvi_consts.svh"

module rvvi_event_arbiter
   import rvvi_pkg::*;
(
   input  logic                                   rvvi,
   input  logic                                   arst_n_i,
   input  logic [`RVVI_REQ_PER_SRC-1:0]           fault_valid_i,
   input  net_event_t [`RVVI_REQ_PER_SRC-1:0]     fault_req_i,
   input  logic [`RVVI_REQ_PER_SRC-1:0]           pin_valid_i,
   input  net_event_t [`RVVI_REQ_PER_SRC-1:0]     pin_req_i,
   input  logic                                   credit_i,
   output logic                                   evt_valid_o,
   output net_event_t                             evt_o
);

   localparam int CRED_W = $clog2(`RVVI_EVT_CREDITS + 1);
   // Highest priority first
   localparam net_id_e PRIO [`RVVI_NUM_NET] = '{
      NET_HALTREQ, NET_NMI_CAUSE, NET_NMI, NET_IBUS_FAULT, NET_IRQ
   };

   logic [`RVVI_NUM_NET-1:0]  pend_q, pend_m, pend_d;
   xlen_t [`RVVI_NUM_NET-1:0] val_q, val_m;
   logic [CRED_W-1:0]         cred_q, cred_d;
   logic                      send;
   net_id_e                   sel;

   always_comb begin
      // Fold in this cycle's requests so a lone event leaves at once
      pend_m = pend_q;
      val_m  = val_q;
      for (int i = 0; i < `RVVI_REQ_PER_SRC; i++) begin
         if (fault_valid_i[i]) begin
            pend_m[fault_req_i[i].id] = 1'b1;
            val_m[fault_req_i[i].id]  = fault_req_i[i].value;
         end
         if (pin_valid_i[i]) begin
            pend_m[pin_req_i[i].id] = 1'b1;
            val_m[pin_req_i[i].id]  = pin_req_i[i].value;
         end
      end

      sel = NET_HALTREQ;
      for (int i = `RVVI_NUM_NET - 1; i >= 0; i--) begin
         if (pend_m[PRIO[i]]) begin
            sel = PRIO[i];
         end
      end

      send   = (cred_q != '0) && (pend_m != '0);
      pend_d = pend_m;
      if (send) begin
         pend_d[sel] = 1'b0;
      end
      cred_d = cred_q - CRED_W'(send) + CRED_W'(credit_i);
   end

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pend_q      <= '0;
         val_q       <= '0;
         cred_q      <= CRED_W'(`RVVI_EVT_CREDITS);
         evt_valid_o <= 1'b0;
         evt_o       <= '0;
      end else begin
         pend_q      <= pend_d;
         val_q       <= val_m;
         cred_q      <= cred_d;
         evt_valid_o <= send;
         if (send) begin
            evt_o.id    <= sel;
            evt_o.value <= val_m[sel];
         end
      end
   end

endmodule

// ==== design/rvvi_tracer_top.sv ====
//////////////////////////////
// Retirement tracer top level
// Formatter, fault tracker, pin watcher, arbiter
//////////////////////////////

`timescale 1ns/10ps
`include "rvvi_consts.svh"

module rvvi_tracer_top
   import rvvi_pkg::*;
(
   input  logic                          rvvi,
   input  logic                          arst_n_i,
   input  retire_rec_t                   retire_i,
   input  csr_port_t [`RVVI_NUM_CSR-1:0] csr_i,
   input  xlen_t                         irq_i,
   input  logic                          debug_req_i,
   input  logic                          credit_i,
   output trace_rec_t                    trace_o,
   output logic                          evt_valid_o,
   output net_event_t                    evt_o
);

   logic [`RVVI_REQ_PER_SRC-1:0]       fault_valid;
   net_event_t [`RVVI_REQ_PER_SRC-1:0] fault_req;
   logic [`RVVI_REQ_PER_SRC-1:0]       pin_valid;
   net_event_t [`RVVI_REQ_PER_SRC-1:0] pin_req;

   // Trace stream
   rvvi_retire_fmt u_retire_fmt (
      .rvvi     (rvvi),
      .arst_n_i (arst_n_i),
      .retire_i (retire_i),
      .csr_i    (csr_i),
      .trace_o  (trace_o)
   );

   // Net event sources
   rvvi_fault_tracker u_fault_tracker (
      .rvvi        (rvvi),
      .arst_n_i    (arst_n_i),
      .retire_i    (retire_i),
      .req_valid_o (fault_valid),
      .req_o       (fault_req)
   );

   rvvi_pin_watch u_pin_watch (
      .rvvi        (rvvi),
      .arst_n_i    (arst_n_i),
      .irq_i       (irq_i),
      .debug_req_i (debug_req_i),
      .req_valid_o (pin_valid),
      .req_o       (pin_req)
   );

   rvvi_event_arbiter u_event_arbiter (
      .rvvi          (rvvi),
      .arst_n_i      (arst_n_i),
      .fault_valid_i (fault_valid),
      .fault_req_i   (fault_req),
      .pin_valid_i   (pin_valid),
      .pin_req_i     (pin_req),
      .credit_i      (credit_i),
      .evt_valid_o   (evt_valid_o),
      .evt_o         (evt_o)
   );

endmodule

// ==== tests/rvvi_tracer_checker.sv ====
//////////////////////////////
// Checker of the retirement tracer
// Trace record compare per retirement
// Ordered event compare, stall and halt checks
// Per-test report
//////////////////////////////

`timescale 1ns/10ps
`include "rvvi_consts.svh"

module rvvi_tracer_checker
   import rvvi_pkg::*;
(
   input  logic                          rvvi,
   input  logic                          arst_n_i,
   input  retire_rec_t                   retire_i,
   input  csr_port_t [`RVVI_NUM_CSR-1:0] csr_i,
   input  logic                          debug_req_i,
   input  logic                          stall_i,
   input  trace_rec_t                    trace_i,
   input  logic                          evt_valid_i,
   input  net_event_t                    evt_i
);

   net_event_t                exp_q [$];
   trace_rec_t                exp_rec;
   logic                      exp_pend = 1'b0;
   xlen_t [`RVVI_NUM_CSR-1:0] last_val = '0;
   logic                      dbg_prev = 1'b0;
   longint                    cycle = 0;
   longint                    drop_cyc = 0;
   int                        stall_sent = 0;
   int                        error_count = 0;
   int                        err_mark = 0;
   int                        tests_run = 0;
   int                        tests_failed = 0;

   function void expect_event(input net_event_t e);
      exp_q.push_back(e);
   endfunction

   function int pending();
      return exp_q.size();
   endfunction

   task automatic report_error(input string msg);
      error_count++;
      $display("ERROR @ %0t: %s", $time, msg);
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (error_count == err_mark) begin
         $display("Test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed, %0d errors", tests_run, name, error_count - err_mark);
      end
      err_mark = error_count;
   endtask

   // Expected record from the retirement and the CSR ports
   function automatic trace_rec_t expect_trace(input retire_rec_t r,
                                               input csr_port_t [`RVVI_NUM_CSR-1:0] c,
                                               input xlen_t [`RVVI_NUM_CSR-1:0] prev);
      trace_rec_t t;
      t          = '0;
      t.valid    = 1'b1;
      t.order    = r.order;
      t.insn     = r.insn;
      t.pc_rdata = r.pc_rdata;
      t.pc_wdata = r.pc_wdata;
      if (r.rd_addr != 0) begin
         t.x_wb = xlen_t'(1) << r.rd_addr;
      end
      t.x_wdata     = r.rd_wdata;
      t.csr_addr[0] = `RVVI_CSR_MSTATUS;
      t.csr_addr[1] = `RVVI_CSR_MEPC;
      t.csr_addr[2] = `RVVI_CSR_MCAUSE;
      t.csr_addr[3] = `RVVI_CSR_MSCRATCH;
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         t.csr_val[i] = (c[i].wdata & c[i].wmask) | (c[i].rdata & c[i].rmask & ~c[i].wmask);
         t.csr_wb[i]  = t.csr_val[i] != prev[i];
      end
      return t;
   endfunction

   task automatic check_trace();
      if (!trace_i.valid) begin
         report_error($sformatf("no trace record for order %0d", exp_rec.order));
      end else begin
         if ({trace_i.order, trace_i.insn, trace_i.pc_rdata, trace_i.pc_wdata} !==
             {exp_rec.order, exp_rec.insn, exp_rec.pc_rdata, exp_rec.pc_wdata}) begin
            report_error($sformatf("order/insn/PC mismatch, order %0d", exp_rec.order));
         end
         if (trace_i.x_wb !== exp_rec.x_wb || trace_i.x_wdata !== exp_rec.x_wdata) begin
            report_error($sformatf("GPR wb got %h/%h, expected %h/%h", trace_i.x_wb,
                                   trace_i.x_wdata, exp_rec.x_wb, exp_rec.x_wdata));
         end
         if (trace_i.csr_addr !== exp_rec.csr_addr || trace_i.csr_val !== exp_rec.csr_val) begin
            report_error($sformatf("csr_val got %h, expected %h", trace_i.csr_val,
                                   exp_rec.csr_val));
         end
         if (trace_i.csr_wb !== exp_rec.csr_wb) begin
            report_error($sformatf("csr_wb got %b, expected %b", trace_i.csr_wb, exp_rec.csr_wb));
         end
      end
   endtask

   task automatic check_event();
      net_event_t e;
      if (stall_i) begin
         stall_sent++;
         if (stall_sent > `RVVI_EVT_CREDITS) begin
            report_error("event sent without credit during stall");
         end
      end
      if (exp_q.size() == 0) begin
         report_error($sformatf("unexpected event id %0d value %h", evt_i.id, evt_i.value));
      end else begin
         e = exp_q.pop_front();
         if (evt_i !== e) begin
            report_error($sformatf("event got id %0d value %h, expected id %0d value %h",
                                   evt_i.id, evt_i.value, e.id, e.value));
         end
      end
      // Halt release must respect the hold time
      if (evt_i.id == NET_HALTREQ && evt_i.value == 0 &&
          cycle - drop_cyc < `RVVI_HALT_HOLD) begin
         report_error($sformatf("HALTREQ 0 only %0d cycles after pin drop", cycle - drop_cyc));
      end
   endtask

   always @(posedge rvvi) begin
      if (!arst_n_i) begin
         exp_pend   = 1'b0;
         last_val   = '0;
         dbg_prev   = 1'b0;
         stall_sent = 0;
      end else begin
         cycle++;
         if (exp_pend) begin
            check_trace();
         end else if (trace_i.valid) begin
            report_error("trace record without a retirement");
         end
         exp_pend = retire_i.valid;
         if (retire_i.valid) begin
            exp_rec  = expect_trace(retire_i, csr_i, last_val);
            last_val = exp_rec.csr_val;
         end

         if (dbg_prev && !debug_req_i) begin
            drop_cyc = cycle;
         end
         dbg_prev = debug_req_i;

         if (!stall_i) begin
            stall_sent = 0;
         end
         if (evt_valid_i) begin
            check_event();
         end
      end
   end

endmodule

// ==== tests/tb_rvvi_tracer.sv ====
//////////////////////////////
// Testbench of the retirement tracer
// Clock, reset, stimulus table and loop
// Credit return and final summary
//////////////////////////////

`timescale 1ns/10ps
`include "rvvi_consts.svh"

module tb_rvvi_tracer
   import rvvi_pkg::*;
();

   localparam logic [2:0] K_NONE   = 3'd0;
   localparam logic [2:0] K_NORM   = 3'd1;
   localparam logic [2:0] K_NMI_LD = 3'd2;
   localparam logic [2:0] K_NMI_ST = 3'd3;
   localparam logic [2:0] K_TRAP   = 3'd4;
   localparam int SETTLE      = 4;
   localparam int EVT_TIMEOUT = 200;
   localparam int MAX_ROWS    = 32;

   // One table row
   typedef struct packed {
      logic [3:0]       test;
      logic [2:0]       kind;
      logic [4:0]       rd;
      logic [3:0]       csr_upd;
      xlen_t            irq;
      logic             dbg;
      logic             stall;
      logic             sync;
      logic [1:0]       n_evt;
      net_event_t [2:0] evt;
   } step_t;

   logic                          rvvi;
   logic                          arst_n_i;
   retire_rec_t                   retire_i;
   csr_port_t [`RVVI_NUM_CSR-1:0] csr_i;
   xlen_t                         irq_i;
   logic                          debug_req_i;
   logic                          credit_i = 1'b0;
   logic                          stall;
   trace_rec_t                    trace_o;
   logic                          evt_valid_o;
   net_event_t                    evt_o;

   step_t                         tbl [MAX_ROWS];
   int                            n_rows = 0;
   string                         test_name [1:6];
   integer                        seed = 32'h017b_a2cd;
   logic [63:0]                   order_cnt = 64'h100;
   csr_port_t [`RVVI_NUM_CSR-1:0] csr_next = '0;
   int                            owed = 0;
   bit                            timed_out = 1'b0;

   rvvi_tracer_top uut (
      .rvvi        (rvvi),
      .arst_n_i    (arst_n_i),
      .retire_i    (retire_i),
      .csr_i       (csr_i),
      .irq_i       (irq_i),
      .debug_req_i (debug_req_i),
      .credit_i    (credit_i),
      .trace_o     (trace_o),
      .evt_valid_o (evt_valid_o),
      .evt_o       (evt_o)
   );

   rvvi_tracer_checker chk (
      .rvvi        (rvvi),
      .arst_n_i    (arst_n_i),
      .retire_i    (retire_i),
      .csr_i       (csr_i),
      .debug_req_i (debug_req_i),
      .stall_i     (stall),
      .trace_i     (trace_o),
      .evt_valid_i (evt_valid_o),
      .evt_i       (evt_o)
   );

   initial begin
      rvvi = 1'b0;
      forever #50 rvvi = ~rvvi;
   end

   // Consumer returns one credit per event unless stalled
   always @(posedge rvvi) begin
      if (!arst_n_i) begin
         owed = 0;
         credit_i <= 1'b0;
      end else begin
         if (evt_valid_o) begin
            owed++;
         end
         if (!stall && owed > 0) begin
            credit_i <= 1'b1;
            owed--;
         end else begin
            credit_i <= 1'b0;
         end
      end
   end

   ///////////////////////////////
   // Table building

   task automatic add_row(input int test, input logic [2:0] kind, input int rd,
                          input logic [3:0] csr, input xlen_t irq, input logic dbg,
                          input logic stl, input logic sync);
      step_t s;
      s         = '0;
      s.test    = 4'(test);
      s.kind    = kind;
      s.rd      = 5'(rd);
      s.csr_upd = csr;
      s.irq     = irq;
      s.dbg     = dbg;
      s.stall   = stl;
      s.sync    = sync;
      tbl[n_rows] = s;
      n_rows++;
   endtask

   task automatic add_evt(input net_id_e id, input xlen_t value);
      step_t s;
      s = tbl[n_rows-1];
      s.evt[s.n_evt].id    = id;
      s.evt[s.n_evt].value = value;
      s.n_evt++;
      tbl[n_rows-1] = s;
   endtask

   task automatic build_table();
      test_name[1] = "trace and GPR writeback";
      test_name[2] = "CSR merge and written flags";
      test_name[3] = "NMI and bus fault events";
      test_name[4] = "interrupt lines";
      test_name[5] = "halt request";
      test_name[6] = "credits and back-pressure";
      add_row(1, K_NORM, 5, 4'hF, 32'h0, 0, 0, 1);
      add_row(1, K_NORM, 0, 4'h0, 32'h0, 0, 0, 1);
      add_row(1, K_NORM, 31, 4'h2, 32'h0, 0, 0, 1);
      add_row(1, K_NORM, 1, 4'h0, 32'h0, 0, 0, 1);
      add_row(2, K_NORM, 7, 4'h5, 32'h0, 0, 0, 1);
      add_row(2, K_NORM, 8, 4'h0, 32'h0, 0, 0, 1);
      add_row(2, K_NORM, 9, 4'h8, 32'h0, 0, 0, 1);
      // CSR change between retirements
      add_row(2, K_NONE, 0, 4'h6, 32'h0, 0, 0, 1);
      add_row(2, K_NORM, 10, 4'h0, 32'h0, 0, 0, 1);
      add_row(3, K_NMI_ST, 0, 4'h0, 32'h0, 0, 0, 1);
      add_evt(NET_NMI_CAUSE, 32'd1025);
      add_evt(NET_NMI, 32'd1);
      add_row(3, K_NMI_ST, 0, 4'h0, 32'h0, 0, 0, 1);
      add_evt(NET_NMI_CAUSE, 32'd1025);
      add_row(3, K_NORM, 2, 4'h0, 32'h0, 0, 0, 1);
      add_evt(NET_NMI, 32'd0);
      add_row(3, K_TRAP, 0, 4'h0, 32'h0, 0, 0, 1);
      add_evt(NET_IBUS_FAULT, 32'd1);
      add_row(3, K_NORM, 3, 4'h0, 32'h0, 0, 0, 1);
      add_evt(NET_IBUS_FAULT, 32'd0);
      add_row(4, K_NONE, 0, 4'h0, 32'h0000_0088, 0, 0, 1);
      add_evt(NET_IRQ, 32'h0000_0088 & `RVVI_IRQ_MASK);
      // Bit 0 is not observed
      add_row(4, K_NONE, 0, 4'h0, 32'h0000_0089, 0, 0, 1);
      add_row(4, K_NONE, 0, 4'h0, 32'h0001_0089, 0, 0, 1);
      add_evt(NET_IRQ, 32'h0001_0089 & `RVVI_IRQ_MASK);
      add_row(4, K_NONE, 0, 4'h0, 32'h0001_0001, 0, 0, 1);
      add_evt(NET_IRQ, 32'h0001_0001 & `RVVI_IRQ_MASK);
      add_row(5, K_NONE, 0, 4'h0, 32'h0001_0001, 1, 0, 1);
      add_evt(NET_HALTREQ, 32'd1);
      add_evt(NET_HALTREQ, 32'd0);
      // Stall uses up both credits and the rest coalesces
      add_row(6, K_NMI_LD, 0, 4'h0, 32'h0001_0001, 0, 1, 0);
      add_evt(NET_NMI_CAUSE, 32'd1024);
      add_evt(NET_NMI, 32'd1);
      add_row(6, K_NORM, 4, 4'h0, 32'h0000_0008, 0, 1, 0);
      add_row(6, K_TRAP, 0, 4'h0, 32'h0000_0080, 0, 1, 0);
      add_row(6, K_NONE, 0, 4'h0, 32'h0000_0080, 0, 0, 1);
      add_evt(NET_NMI, 32'd0);
      add_evt(NET_IBUS_FAULT, 32'd1);
      add_evt(NET_IRQ, 32'h0000_0080 & `RVVI_IRQ_MASK);
   endtask

   ///////////////////////////////
   // Stimulus helpers

   task automatic make_retire(input logic [2:0] kind, input logic [4:0] rd,
                              output retire_rec_t r);
      r          = '0;
      r.valid    = kind != K_NONE;
      r.order    = order_cnt;
      r.insn     = $random(seed);
      r.pc_rdata = $random(seed);
      r.pc_wdata = $random(seed);
      r.rd_addr  = rd;
      r.rd_wdata = $random(seed);
      case (kind)
         K_NMI_LD, K_NMI_ST: begin
            r.intr.intr      = 1'b1;
            r.intr.interrupt = 1'b1;
            r.intr.cause     = (kind == K_NMI_LD) ? `RVVI_NMI_LOAD_CAUSE : `RVVI_NMI_STORE_CAUSE;
         end
         K_TRAP: begin
            r.trap.trap      = 1'b1;
            r.trap.exception = 1'b1;
            r.trap.cause     = `RVVI_IBUS_FAULT_CAUSE;
         end
         default: ;
      endcase
      if (r.valid) begin
         order_cnt++;
      end
   endtask

   task automatic update_csr(input logic [3:0] upd);
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         if (upd[i]) begin
            csr_next[i].wdata = $random(seed);
            csr_next[i].wmask = $random(seed);
            csr_next[i].rdata = $random(seed);
            csr_next[i].rmask = $random(seed);
         end
      end
   endtask

   task automatic wait_events(output bit ok);
      int n;
      n = 0;
      while (chk.pending() != 0 && n < EVT_TIMEOUT) begin
         @(posedge rvvi);
         n++;
      end
      ok = chk.pending() == 0;
   endtask

   initial begin : main
      step_t       s;
      retire_rec_t rec;
      bit          ok;
      arst_n_i    = 1'b0;
      retire_i    = '0;
      csr_i       = '0;
      irq_i       = '0;
      debug_req_i = 1'b0;
      stall       = 1'b0;
      build_table();
      repeat (16) @(posedge rvvi);
      arst_n_i <= 1'b1;

      for (int r = 0; r < n_rows && !timed_out; r++) begin
         s = tbl[r];
         make_retire(s.kind, s.rd, rec);
         update_csr(s.csr_upd);
         for (int k = 0; k < s.n_evt; k++) begin
            chk.expect_event(s.evt[k]);
         end
         @(posedge rvvi);
         retire_i    <= rec;
         csr_i       <= csr_next;
         irq_i       <= s.irq;
         debug_req_i <= s.dbg;
         stall       <= s.stall;
         @(posedge rvvi);
         retire_i.valid <= 1'b0;
         debug_req_i    <= 1'b0;
         if (s.sync) begin
            wait_events(ok);
            if (!ok) begin
               $display("Timeout: events of test %s did not arrive", test_name[s.test]);
               timed_out = 1'b1;
            end
         end
         // Room for any unexpected event to show up
         repeat (SETTLE) @(posedge rvvi);
         if (!timed_out && (r == n_rows - 1 || tbl[r+1].test != s.test)) begin
            chk.report_test(test_name[s.test]);
         end
      end

      $display("Summary: %0d tests run, %0d failed, %0d errors",
               chk.tests_run, chk.tests_failed, chk.error_count);
      if (timed_out || chk.error_count != 0 || chk.pending() != 0) begin
         $display("Done: errors found");
      end else begin
         $display("Done: no errors");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+design
design/rvvi_pkg.sv
design/rvvi_csr_merge.sv
design/rvvi_retire_fmt.sv
design/rvvi_fault_tracker.sv
design/rvvi_pin_watch.sv
design/rvvi_event_arbiter.sv
design/rvvi_tracer_top.sv
tests/rvvi_tracer_checker.sv
tests/tb_rvvi_tracer.sv

// ==== Bender.yml ====
package:
  name: rvvi_tracer

export_include_dirs:
  - design

sources:
  - design/rvvi_pkg.sv
  - design/rvvi_csr_merge.sv
  - design/rvvi_retire_fmt.sv
  - design/rvvi_fault_tracker.sv
  - design/rvvi_pin_watch.sv
  - design/rvvi_event_arbiter.sv
  - design/rvvi_tracer_top.sv
  - target: test
    files:
      - tests/rvvi_tracer_checker.sv
      - tests/tb_rvvi_tracer.sv
